//--- Bender.yml
package:
  name: stream_classifier

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/match_pkg.sv
      - verilog/pkt_ctrl.sv
      - verilog/stream_state_mem.sv
      - verilog/dfa_keyword.sv
      - verilog/match_counter.sv
      - verilog/category_matcher.sv
      - verilog/stream_classifier.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/tb_stream_classifier.sv

//--- all.f
+incdir+verilog
verilog/match_pkg.sv
verilog/pkt_ctrl.sv
verilog/stream_state_mem.sv
verilog/dfa_keyword.sv
verilog/match_counter.sv
verilog/category_matcher.sv
verilog/stream_classifier.sv
verification/tb_stream_classifier.sv

//--- verification/tb_stream_classifier.sv
`timescale 1ns/1ns
`include "match_consts.svh"

module tb_stream_classifier;

  import match_pkg::*;

  localparam int NUM_RANDOM = 400;
  localparam int MAX_LEN = 12;
  localparam int TOTAL_PKTS = NUM_RANDOM + 16;
  // Start, load, bytes with at most one gap each, end, flush and done
  localparam int TIMEOUT_CYCLES = TOTAL_PKTS * (2 * MAX_LEN + 12) + 100;
  // Byte alphabet biased toward both keywords
  localparam logic [47:0] LETTERS = "msnaim";

  logic       clk;
  logic       rst_n;
  logic       pkt_start;
  stream_id_t stream_id;
  logic       new_stream;
  logic [1:0] enable_mask;
  logic       char_vld;
  char_t      char_in;
  logic       pkt_end;
  logic       ready;
  count_t     count_0;
  count_t     count_1;
  logic [1:0] fired;
  logic       done;

  // Reference model, last two accepted bytes per category and stream
  logic [23:0] keyword [2];
  logic [15:0] hist [2][`MATCH_NUM_STREAMS];
  bit          hist_ok [2][`MATCH_NUM_STREAMS];
  count_t      exp_count [2];
  char_t       payload [$];
  char_t       accepted [$];
  logic [31:0] rng_state;
  int          cycles = 0;
  // Expected byte window of the current packet, and its name for reports
  bit          window;
  string       pkt_name;

  stream_classifier stream_classifier_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .pkt_start   (pkt_start),
    .stream_id   (stream_id),
    .new_stream  (new_stream),
    .enable_mask (enable_mask),
    .char_vld    (char_vld),
    .char_in     (char_in),
    .pkt_end     (pkt_end),
    .ready       (ready),
    .count_0     (count_0),
    .count_1     (count_1),
    .fired       (fired),
    .done        (done)
  );

  initial
    clk = 1'b0;
  always #20 clk = ~clk;

  // Hang guard
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  // LCG step
  function automatic logic [15:0] next_random();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state[30:15];
  endfunction

  function automatic int unsigned rand_range(input int unsigned n);
    return next_random() % n;
  endfunction

  // Mostly keyword letters so that matches are frequent
  function automatic char_t pick_byte();
    if (rand_range(10) < 8)
      return LETTERS[8 * rand_range(6) +: 8];
    else
      return char_t'(rand_range(256));
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("ERR %s expected %0h actual %0h", name, expected, actual);
      $display("TESTS FAILED");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic set_text(input string text);
    payload.delete();
    for (int i = 0; i < text.len(); i++)
      payload.push_back(text[i]);
  endtask

  // One clock of stimulus, then sample just after the edge
  task automatic drive_cycle(input logic vld, input char_t c, input logic fin);
    @(posedge clk);
    pkt_start <= 1'b0;
    char_vld  <= vld;
    char_in   <= c;
    pkt_end   <= fin;
    #1;
    // Window opens 3 cycles after the start and closes after the end cycle
    check_value({pkt_name, " ready"}, window, ready);
    if (vld && window)
      accepted.push_back(c);
  endtask

  // Scan the accepted bytes per category and commit the enabled ones
  task automatic model_packet(input int s, input bit new_s, input logic [1:0] mask,
                              output logic [1:0] hit);
    logic [15:0] work;
    for (int c = 0; c < 2; c++)
    begin
      work = new_s ? 16'd0 : hist[c][s];
      hit[c] = 1'b0;
      foreach (accepted[i])
      begin
        if ({work, accepted[i]} == keyword[c])
          hit[c] = 1'b1;
        work = {work[7:0], accepted[i]};
      end
      // Disabled category keeps its older history
      if (mask[c])
      begin
        hist[c][s] = work;
        hist_ok[c][s] = 1'b1;
        exp_count[c] = exp_count[c] + count_t'(hit[c]);
      end
    end
  endtask

  task automatic run_packet(input string name, input int s, input bit new_s,
                            input logic [1:0] mask, input bit noisy);
    logic [1:0] hit;
    pkt_name = name;
    accepted.delete();
    window = 1'b0;
    @(posedge clk);
    pkt_start   <= 1'b1;
    stream_id   <= stream_id_t'(s);
    new_stream  <= new_s;
    enable_mask <= mask;
    char_vld    <= 1'b0;
    pkt_end     <= 1'b0;
    #1;
    // Noise while the state is restored, ready rises on the third cycle
    for (int i = 1; i <= 3; i++)
    begin
      window = (i == 3);
      drive_cycle(noisy && (rand_range(2) == 0), pick_byte(), 1'b0);
    end
    foreach (payload[i])
    begin
      if (noisy && (rand_range(4) == 0))
        drive_cycle(1'b0, pick_byte(), 1'b0);
      drive_cycle(1'b1, payload[i], 1'b0);
    end
    // End cycle is still inside the window
    drive_cycle(noisy && (rand_range(2) == 0), pick_byte(), 1'b1);
    window = 1'b0;
    do
      drive_cycle(noisy && (rand_range(2) == 0), pick_byte(), 1'b0);
    while (!done);
    model_packet(s, new_s, mask, hit);
    check_value({name, " count_0"}, exp_count[0], count_0);
    check_value({name, " count_1"}, exp_count[1], count_1);
    check_value({name, " fired"}, mask & hit, fired);
  endtask

  task automatic expect_counts(input string name, input int e0, input int e1);
    check_value({name, " total 0"}, e0, count_0);
    check_value({name, " total 1"}, e1, count_1);
  endtask

  initial
  begin : main_seq
    int         s;
    bit         new_s;
    logic [1:0] mask;
    int         len;
    rng_state = 32'd7429;
    keyword[0] = `MATCH_KEYWORD_0;
    keyword[1] = `MATCH_KEYWORD_1;
    exp_count[0] = '0;
    exp_count[1] = '0;
    rst_n       = 1'b0;
    pkt_start   = 1'b0;
    stream_id   = '0;
    new_stream  = 1'b0;
    enable_mask = 2'b00;
    char_vld    = 1'b0;
    char_in     = '0;
    pkt_end     = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    #1;
    check_value("reset ready", 0, ready);
    check_value("reset done", 0, done);
    check_value("reset fired", 0, fired);
    check_value("reset count_0", 0, count_0);
    check_value("reset count_1", 0, count_1);

    // Fresh streams, both categories on
    set_text("xmsnq");
    run_packet("single msn", 1, 1'b1, 2'b11, 1'b0);
    set_text("aimsn");
    run_packet("single both", 2, 1'b1, 2'b11, 1'b0);
    set_text("maisn");
    run_packet("single none", 3, 1'b1, 2'b11, 1'b0);
    expect_counts("single", 2, 1);

    // Keyword split over two packets of one stream
    set_text("zzms");
    run_packet("split head", 4, 1'b1, 2'b11, 1'b0);
    set_text("nq");
    run_packet("split tail", 4, 1'b0, 2'b11, 1'b0);
    expect_counts("split kept", 3, 1);
    set_text("ms");
    run_packet("split cleared head", 5, 1'b1, 2'b11, 1'b0);
    set_text("nq");
    run_packet("split cleared tail", 5, 1'b1, 2'b11, 1'b0);
    expect_counts("split cleared", 3, 1);

    // Two streams interleaved
    set_text("a");
    run_packet("mix 6a", 6, 1'b1, 2'b11, 1'b0);
    set_text("ai");
    run_packet("mix 7a", 7, 1'b1, 2'b11, 1'b0);
    set_text("im");
    run_packet("mix 6b", 6, 1'b0, 2'b11, 1'b0);
    set_text("m");
    run_packet("mix 7b", 7, 1'b0, 2'b11, 1'b0);
    expect_counts("interleave", 3, 3);

    // Disabled category leaves count and history alone
    set_text("xa");
    run_packet("disable seed", 8, 1'b1, 2'b11, 1'b0);
    set_text("ix");
    run_packet("disable skip", 8, 1'b0, 2'b01, 1'b0);
    expect_counts("disable skip", 3, 3);
    set_text("im");
    run_packet("disable resume", 8, 1'b0, 2'b11, 1'b0);
    expect_counts("disable resume", 3, 4);
    set_text("msn");
    run_packet("disable hit 0", 9, 1'b1, 2'b10, 1'b0);
    set_text("aim");
    run_packet("disable hit 1", 10, 1'b1, 2'b01, 1'b0);
    expect_counts("disable hits", 3, 4);

    // Random interleaved traffic, a few streams are hot
    for (int n = 0; n < NUM_RANDOM; n++)
    begin
      if (rand_range(2) == 0)
        s = int'(rand_range(4));
      else
        s = int'(rand_range(`MATCH_NUM_STREAMS));
      mask = 2'(rand_range(4));
      // Unwritten memory words need a cleared start
      new_s = (rand_range(5) == 0) || !hist_ok[0][s] || !hist_ok[1][s];
      len = 1 + int'(rand_range(MAX_LEN));
      payload.delete();
      repeat (len)
        payload.push_back(pick_byte());
      run_packet($sformatf("random %0d", n), s, new_s, mask, 1'b1);
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- verilog/category_matcher.sv
`timescale 1ns/1ns
`include "match_consts.svh"

module category_matcher #(
  parameter logic [8*`MATCH_KEYWORD_LEN-1:0] KEYWORD = `MATCH_KEYWORD_0
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  char_vld,
  input  logic                  load_state,
  input  logic                  clear_state,
  input  logic                  commit,
  input  logic                  enable,
  input  match_pkg::char_t      char_in,
  input  match_pkg::stream_id_t cur_stream,
  output match_pkg::count_t     count,
  output logic                  fired
);

  import match_pkg::*;

  // Memory to input register
  dfa_state_t mem_state;
  logic       mem_state_vld;

  // Automaton input register
  char_t      char_r;
  logic       char_vld_r;
  dfa_state_t state_in_r;
  logic       state_in_vld_r;

  // Automaton outputs, raw and registered
  dfa_state_t dfa_state;
  logic       dfa_accept;
  dfa_state_t state_out_r;
  logic       accept_r;

  stream_state_mem stream_state_mem_i (
    .clk           (clk),
    .load_state    (load_state),
    .clear_state   (clear_state),
    .save          (commit & enable),
    .rd_stream     (cur_stream),
    .wr_stream     (cur_stream),
    .save_state    (state_out_r),
    .state_out     (mem_state),
    .state_out_vld (mem_state_vld)
  );

  // Both sides of the automaton registered for timing
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      char_vld_r     <= 1'b0;
      state_in_vld_r <= 1'b0;
      accept_r       <= 1'b0;
    end
    else
    begin
      char_vld_r     <= char_vld;
      state_in_vld_r <= mem_state_vld;
      accept_r       <= dfa_accept;
    end
  end

  always_ff @(posedge clk)
  begin
    char_r      <= char_in;
    state_in_r  <= mem_state;
    // Saved at commit once the last byte has drained
    state_out_r <= dfa_state;
  end

  dfa_keyword #(
    .KEYWORD (KEYWORD)
  ) dfa_keyword_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .char_in      (char_r),
    .char_vld     (char_vld_r),
    .state_in_vld (state_in_vld_r),
    .state_in     (state_in_r),
    .state_out    (dfa_state),
    .accept_out   (dfa_accept)
  );

  match_counter match_counter_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_state (load_state),
    .accept     (accept_r),
    .commit     (commit),
    .enable     (enable),
    .count      (count),
    .fired      (fired)
  );

endmodule

//--- verilog/dfa_keyword.sv
`timescale 1ns/1ns
`include "match_consts.svh"

module dfa_keyword #(
  parameter logic [8*`MATCH_KEYWORD_LEN-1:0] KEYWORD = `MATCH_KEYWORD_0
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  match_pkg::char_t      char_in,
  input  logic                  char_vld,
  input  logic                  state_in_vld,
  input  match_pkg::dfa_state_t state_in,
  output match_pkg::dfa_state_t state_out,
  output logic                  accept_out
);

  import match_pkg::*;

  localparam int KW_LEN = `MATCH_KEYWORD_LEN;

  // Keyword character by position, position 0 is the first character
  function automatic char_t kw_char(input int idx);
    return KEYWORD[8*(KW_LEN-1-idx) +: 8];
  endfunction

  // Longest keyword prefix that is a suffix of prefix(s) followed by c
  function automatic int prefix_match(input int s, input char_t c);
    int   best;
    int   pos;
    logic ok;
    best = 0;
    for (int k = 1; k <= KW_LEN; k++)
    begin
      ok = (k <= s + 1);
      for (int j = 0; j < KW_LEN; j++)
      begin
        if (ok && (j < k))
        begin
          pos = s + 1 - k + j;
          // The newest text character is c, the rest is the matched prefix
          if (pos == s)
            ok = (c == kw_char(j));
          else
            ok = (kw_char(pos) == kw_char(j));
        end
      end
      if (ok)
        best = k;
    end
    return best;
  endfunction

  // Longest proper prefix of the keyword that is also its suffix
  function automatic int border_len();
    int   best;
    logic ok;
    best = 0;
    for (int k = 1; k < KW_LEN; k++)
    begin
      ok = 1'b1;
      for (int j = 0; j < k; j++)
      begin
        if (kw_char(KW_LEN - k + j) != kw_char(j))
          ok = 1'b0;
      end
      if (ok)
        best = k;
    end
    return best;
  endfunction

  // Fallback state after a full match
  localparam int BORDER = border_len();

  dfa_state_t state;
  dfa_state_t next_state;
  int         cur_len;
  int         match_len;

  always_comb
  begin
    // Out-of-range restored states count as the empty prefix
    cur_len    = (state < KW_LEN) ? int'(state) : 0;
    match_len  = prefix_match(cur_len, char_in);
    accept_out = char_vld && (match_len == KW_LEN);
    if (match_len == KW_LEN)
      next_state = dfa_state_t'(BORDER);
    else
      next_state = dfa_state_t'(match_len);
  end

  // Restore has priority, bytes never arrive in the same cycle
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      state <= '0;
    else if (state_in_vld)
      state <= state_in;
    else if (char_vld)
      state <= next_state;
  end

  assign state_out = state;

endmodule

//--- verilog/match_consts.svh
`ifndef MATCH_CONSTS_SVH
`define MATCH_CONSTS_SVH

// Number of interleaved streams and the width of a stream id
`define MATCH_NUM_STREAMS 64
`define MATCH_STREAM_W 6

// Automaton state width, wider than the literal keywords need
`define MATCH_STATE_W 11

// Matched-packet counter width
`define MATCH_COUNT_W 16

// Literal keywords, one per category, first character in the top byte
`define MATCH_KEYWORD_0 "msn"
`define MATCH_KEYWORD_1 "aim"
`define MATCH_KEYWORD_LEN 3

// Cycles from the last accepted byte until its accept bit reaches the counter
`define MATCH_FLUSH_CYCLES 3

`endif

//--- verilog/match_counter.sv
`timescale 1ns/1ns

module match_counter (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              load_state,
  input  logic              accept,
  input  logic              commit,
  input  logic              enable,
  output match_pkg::count_t count,
  output logic              fired
);

  import match_pkg::*;

  // Set by any accept in the current packet
  logic spec_match;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      count      <= '0;
      spec_match <= 1'b0;
    end
    else
    begin
      // New packet starts unmatched
      if (load_state)
        spec_match <= 1'b0;

      if (commit)
      begin
        // Count wraps at full width
        if (enable)
          count <= count + count_t'(spec_match);
        else
          spec_match <= 1'b0;
      end

      // Accept wins over both clears
      if (accept)
        spec_match <= 1'b1;
    end
  end

  assign fired = spec_match;

endmodule

//--- verilog/match_pkg.sv
`include "match_consts.svh"

package match_pkg;

  // One payload byte
  typedef logic [7:0] char_t;

  // Stream index
  typedef logic [`MATCH_STREAM_W-1:0] stream_id_t;

  // Automaton state, the matched prefix length
  typedef logic [`MATCH_STATE_W-1:0] dfa_state_t;

  // Per-category count of matched packets
  typedef logic [`MATCH_COUNT_W-1:0] count_t;

  // Packet sequencing in the controller
  typedef enum logic [1:0]
  {
    IDLE,
    LOAD,
    ACTIVE,
    FLUSH
  } ctrl_state_e;

endpackage

//--- verilog/pkt_ctrl.sv
`timescale 1ns/1ns
`include "match_consts.svh"

module pkt_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  pkt_start,
  input  logic                  pkt_end,
  input  logic                  new_stream,
  input  match_pkg::stream_id_t stream_id,
  input  logic [1:0]            enable_mask,
  output logic                  load_state,
  output logic                  clear_state,
  output logic                  chars_open,
  output logic                  commit,
  output logic                  done,
  output logic                  ready,
  output match_pkg::stream_id_t cur_stream,
  output logic [1:0]            enable_lat
);

  import match_pkg::*;

  // Flush length and the counter that times both LOAD and FLUSH
  localparam int FLUSH_LEN = `MATCH_FLUSH_CYCLES;
  localparam int CNT_W = $clog2(FLUSH_LEN + 1);
  localparam logic [CNT_W-1:0] LOAD_LAST = CNT_W'(1);
  localparam logic [CNT_W-1:0] FLUSH_LAST = CNT_W'(FLUSH_LEN);

  ctrl_state_e      state;
  logic [CNT_W-1:0] cnt;
  logic             new_lat;

  // Packet context, captured only when a packet is accepted
  always_ff @(posedge clk)
  begin
    if ((state == IDLE) && pkt_start)
    begin
      cur_stream <= stream_id;
      new_lat    <= new_stream;
      enable_lat <= enable_mask;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state <= IDLE;
      cnt   <= '0;
      done  <= 1'b0;
    end
    else
    begin
      // done trails commit by one cycle, counts are final by then
      done <= commit;
      case (state)
        IDLE:
        begin
          // Start pulses outside IDLE are ignored
          if (pkt_start)
          begin
            state <= LOAD;
            cnt   <= '0;
          end
        end
        LOAD:
        begin
          // One cycle for the memory read, one for the automaton input register
          if (cnt == LOAD_LAST)
          begin
            state <= ACTIVE;
            cnt   <= '0;
          end
          else
            cnt <= cnt + 1'b1;
        end
        ACTIVE:
        begin
          if (pkt_end)
          begin
            state <= FLUSH;
            cnt   <= '0;
          end
        end
        FLUSH:
        begin
          // Drain the byte, automaton and accept registers, then commit
          if (cnt == FLUSH_LAST)
            state <= IDLE;
          else
            cnt <= cnt + 1'b1;
        end
        default:
          state <= IDLE;
      endcase
    end
  end

  // Restore request in the first LOAD cycle
  assign load_state  = (state == LOAD) && (cnt == '0);
  assign clear_state = new_lat;

  // Byte window
  assign chars_open = (state == ACTIVE);
  assign ready      = chars_open;

  // Last FLUSH cycle
  assign commit = (state == FLUSH) && (cnt == FLUSH_LAST);

endmodule

//--- verilog/stream_classifier.sv
`timescale 1ns/1ns
`include "match_consts.svh"

module stream_classifier (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  pkt_start,
  input  match_pkg::stream_id_t stream_id,
  input  logic                  new_stream,
  input  logic [1:0]            enable_mask,
  input  logic                  char_vld,
  input  match_pkg::char_t      char_in,
  input  logic                  pkt_end,
  output logic                  ready,
  output match_pkg::count_t     count_0,
  output match_pkg::count_t     count_1,
  output logic [1:0]            fired,
  output logic                  done
);

  import match_pkg::*;

  // Controller outputs shared by both categories
  logic       load_state;
  logic       clear_state;
  logic       chars_open;
  logic       commit;
  stream_id_t cur_stream;
  logic [1:0] enable_lat;

  // Bytes outside the window are dropped here
  logic       char_vld_win;

  assign char_vld_win = char_vld & chars_open;

  pkt_ctrl pkt_ctrl_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .pkt_start   (pkt_start),
    .pkt_end     (pkt_end),
    .new_stream  (new_stream),
    .stream_id   (stream_id),
    .enable_mask (enable_mask),
    .load_state  (load_state),
    .clear_state (clear_state),
    .chars_open  (chars_open),
    .commit      (commit),
    .done        (done),
    .ready       (ready),
    .cur_stream  (cur_stream),
    .enable_lat  (enable_lat)
  );

  // Category 0
  category_matcher #(
    .KEYWORD (`MATCH_KEYWORD_0)
  ) category_0_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .char_vld    (char_vld_win),
    .load_state  (load_state),
    .clear_state (clear_state),
    .commit      (commit),
    .enable      (enable_lat[0]),
    .char_in     (char_in),
    .cur_stream  (cur_stream),
    .count       (count_0),
    .fired       (fired[0])
  );

  // Category 1
  category_matcher #(
    .KEYWORD (`MATCH_KEYWORD_1)
  ) category_1_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .char_vld    (char_vld_win),
    .load_state  (load_state),
    .clear_state (clear_state),
    .commit      (commit),
    .enable      (enable_lat[1]),
    .char_in     (char_in),
    .cur_stream  (cur_stream),
    .count       (count_1),
    .fired       (fired[1])
  );

endmodule

//--- verilog/stream_state_mem.sv
`timescale 1ns/1ns
`include "match_consts.svh"

module stream_state_mem (
  input  logic                  clk,
  input  logic                  load_state,
  input  logic                  clear_state,
  input  logic                  save,
  input  match_pkg::stream_id_t rd_stream,
  input  match_pkg::stream_id_t wr_stream,
  input  match_pkg::dfa_state_t save_state,
  output match_pkg::dfa_state_t state_out,
  output logic                  state_out_vld
);

  import match_pkg::*;

  // One saved automaton state per stream
  dfa_state_t mem [`MATCH_NUM_STREAMS];

  // End-of-packet save
  always_ff @(posedge clk)
  begin
    if (save)
      mem[wr_stream] <= save_state;
  end

  // Restore one cycle after the request
  always_ff @(posedge clk)
  begin
    state_out_vld <= load_state;
    if (load_state)
    begin
      // A new stream starts from the empty prefix
      if (clear_state)
        state_out <= '0;
      else
        state_out <= mem[rd_stream];
    end
  end

endmodule
